// ==== Bender.yml ====
package:
  name: exec_backend

sources:
  - src/isa_pkg.sv
  - src/pipe_pkg.sv
  - src/ex_stage.sv
  - src/stage_reg.sv
  - src/mem_stage.sv
  - src/exec_backend.sv
  - target: test
    files:
      - tests/stage_reg_assertions.sv
      - tests/backend_checker.sv
      - tests/tb_exec_backend.sv

// ==== list.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/ex_stage.sv
src/stage_reg.sv
src/mem_stage.sv
src/exec_backend.sv
tests/stage_reg_assertions.sv
tests/backend_checker.sv
tests/tb_exec_backend.sv

// ==== src/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage (
	input  pipe_pkg::issue_t  issue,
	output pipe_pkg::ex_mem_t result
);

	import isa_pkg::*;

	word_t    a;
	word_t    b;
	word_t    alu_out;
	logic [3:0] shamt;
	logic     ovf;
	flags_t   flags;

	assign a     = issue.operand_a;
	assign b     = issue.operand_b;
	assign shamt = b[3:0];

	always_comb begin
		alu_out = '0;
		ovf     = 1'b0;
		case (issue.alu_op)
			alu_add: begin
				alu_out = a + b;
				// same operand signs but the sum flips sign
				ovf = (a[15] == b[15]) && (alu_out[15] != a[15]);
			end
			alu_sub: begin
				alu_out = a - b;
				// differing operand signs and the result leaves the sign of a
				ovf = (a[15] != b[15]) && (alu_out[15] != a[15]);
			end
			alu_and:    alu_out = a & b;
			alu_or:     alu_out = a | b;
			alu_xor:    alu_out = a ^ b;
			alu_sll:    alu_out = a << shamt;
			alu_srl:    alu_out = a >> shamt;
			alu_sra:    alu_out = word_t'($signed(a) >>> shamt);
			alu_pass_b: alu_out = b;
			default:    alu_out = '0;
		endcase
	end

	assign flags.n = alu_out[15];
	assign flags.z = (alu_out == '0);
	assign flags.v = ovf;

	always_comb begin
		result.alu_result = alu_out;
		result.flags      = flags;
		result.sdata      = issue.sdata;
		result.pc         = issue.pc;
		// branch target adder runs alongside the ALU
		result.target     = issue.pc + issue.offset;
		result.dest       = issue.dest;
		result.we_rf      = issue.we_rf;
		result.we_mem     = issue.we_mem;
		result.re_mem     = issue.re_mem;
		result.wb_sel     = issue.wb_sel;
		result.bj_cond    = issue.bj_cond;
	end

endmodule

// ==== src/exec_backend.sv ====
`timescale 1ns/1ns

module exec_backend #(
	parameter int MEM_AW = 6
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  pipe_pkg::issue_t in_data,
	output logic             out_valid,
	input  logic             out_ready,
	output pipe_pkg::wb_t    out_data
);

	import pipe_pkg::*;

	ex_mem_t ex_rec;
	ex_mem_t exm_data;
	logic    exm_valid;
	logic    exm_ready;
	wb_t     wb_rec;
	logic    wb_valid;
	logic    wb_ready;

	ex_stage u_ex_stage (
		.issue  (in_data),
		.result (ex_rec)
	);

	stage_reg #(
		.payload_t (ex_mem_t)
	) u_ex_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (ex_rec),
		.out_valid (exm_valid),
		.out_ready (exm_ready),
		.out_data  (exm_data)
	);

	// memory access and branch resolution sit between the two registers
	mem_stage #(
		.MEM_AW (MEM_AW)
	) u_mem_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (exm_valid),
		.in_ready  (exm_ready),
		.in_data   (exm_data),
		.out_valid (wb_valid),
		.out_ready (wb_ready),
		.out_data  (wb_rec)
	);

	stage_reg #(
		.payload_t (wb_t)
	) u_mem_wb (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (wb_valid),
		.in_ready  (wb_ready),
		.in_data   (wb_rec),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

// ==== src/isa_pkg.sv ====
package isa_pkg;

	// one data word of the machine, the ISA fixes it at 16 bits
	typedef logic [15:0] word_t;

	// eight architectural registers
	typedef logic [2:0] reg_idx_t;

	// shifts take their distance from the low 4 bits of operand b
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_sll    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_pass_b = 4'd8
	} alu_op_t;

	// v is only meaningful after add and sub, the ALU clears it otherwise
	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} flags_t;

	typedef enum logic [2:0] {
		cond_eq     = 3'd0,
		cond_ne     = 3'd1,
		cond_lt     = 3'd2,
		cond_ge     = 3'd3,
		cond_gt     = 3'd4,
		cond_le     = 3'd5,
		cond_ovf    = 3'd6,
		cond_always = 3'd7
	} cond_t;

	typedef enum logic [1:0] {
		ctrl_none   = 2'd0,
		ctrl_branch = 2'd1,
		ctrl_jump   = 2'd2
	} ctrl_kind_t;

	// control transfer descriptor carried down the pipe with the instruction
	typedef struct packed {
		ctrl_kind_t kind;
		cond_t      cond;
	} bj_cond_t;

	// condition table for conditional branches, signed compares use n xor v
	function automatic logic cond_holds(cond_t cond, flags_t flags);
		logic lt;
		logic res;
		lt = flags.n ^ flags.v;
		case (cond)
			cond_eq:     res = flags.z;
			cond_ne:     res = !flags.z;
			cond_lt:     res = lt;
			cond_ge:     res = !lt;
			cond_gt:     res = !flags.z && !lt;
			cond_le:     res = flags.z || lt;
			cond_ovf:    res = flags.v;
			default:     res = 1'b1;
		endcase
		return res;
	endfunction

endpackage

// ==== src/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage #(
	parameter int MEM_AW = 6
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  pipe_pkg::ex_mem_t in_data,
	output logic              out_valid,
	input  logic              out_ready,
	output pipe_pkg::wb_t     out_data
);

	import isa_pkg::*;

	localparam int DEPTH = 2 ** MEM_AW;

	word_t             mem [DEPTH];
	logic [MEM_AW-1:0] addr;
	logic              wr_en;
	word_t             rdata;
	logic              taken;

	// this stage adds no storage to the handshake
	assign out_valid = in_valid;
	assign in_ready  = out_ready;

	assign addr = in_data.alu_result[MEM_AW-1:0];

	// the store lands on the same edge that moves the item into MEM/WB
	assign wr_en = in_valid && out_ready && in_data.we_mem;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[addr] <= in_data.sdata;
		end
	end

	// asynchronous read so a load sees all stores ahead of it
	assign rdata = mem[addr];

	always_comb begin
		case (in_data.bj_cond.kind)
			ctrl_jump:   taken = 1'b1;
			ctrl_branch: taken = cond_holds(in_data.bj_cond.cond, in_data.flags);
			default:     taken = 1'b0;
		endcase
	end

	always_comb begin
		out_data.dest        = in_data.dest;
		out_data.we_rf       = in_data.we_rf;
		out_data.wb_data     = in_data.wb_sel ? rdata : in_data.alu_result;
		out_data.redirect    = taken;
		out_data.redirect_pc = in_data.target;
	end

endmodule

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

	import isa_pkg::*;

	// decoded instruction as it arrives from the issue side
	typedef struct packed {
		alu_op_t  alu_op;
		word_t    operand_a;
		word_t    operand_b;
		// branch and jump displacement, relative to pc
		word_t    offset;
		// store data, already read from the register file
		word_t    sdata;
		word_t    pc;
		reg_idx_t dest;
		logic     we_rf;
		logic     we_mem;
		logic     re_mem;
		// 1 selects the loaded word for writeback
		logic     wb_sel;
		bj_cond_t bj_cond;
	} issue_t;

	// execute result held in the EX/MEM register
	typedef struct packed {
		word_t    alu_result;
		flags_t   flags;
		word_t    sdata;
		word_t    pc;
		// pc plus offset, precomputed in execute
		word_t    target;
		reg_idx_t dest;
		logic     we_rf;
		logic     we_mem;
		logic     re_mem;
		logic     wb_sel;
		bj_cond_t bj_cond;
	} ex_mem_t;

	// writeback record, the consumer applies the register write and the redirect
	typedef struct packed {
		reg_idx_t dest;
		logic     we_rf;
		word_t    wb_data;
		logic     redirect;
		word_t    redirect_pc;
	} wb_t;

endpackage

// ==== src/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic load;

	// an empty slot or a drained one can take the next item
	assign in_ready = !out_valid || out_ready;
	assign load     = in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= in_valid;
		end
	end

	// payload only moves when a new item arrives, otherwise it holds for the stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_data <= payload_t'(0);
		end else if (load && in_valid) begin
			out_data <= in_data;
		end
	end

endmodule

// ==== tests/backend_checker.sv ====
`timescale 1ns/1ns

module backend_checker #(
	parameter int MEM_AW = 6
) (
	input logic             clk,
	input logic             rst_n,
	input logic             in_valid,
	input logic             in_ready,
	input pipe_pkg::issue_t in_data,
	input logic             out_valid,
	input logic             out_ready,
	input pipe_pkg::wb_t    out_data
);

	import isa_pkg::*;
	import pipe_pkg::*;

	word_t model_mem [2 ** MEM_AW];
	wb_t   exp_q [$];
	int    accept_q [$];
	int    cycle = 0;
	int    last_stall = 0;
	int    error_count = 0;
	logic  seen_input = 1'b0;

	initial begin
		foreach (model_mem[i]) begin
			model_mem[i] = '0;
		end
	end

	// expected writeback of one instruction, stores land in the model in program order
	function automatic wb_t predict(input issue_t it);
		wb_t        w;
		int         sum;
		word_t      res;
		logic       v;
		logic       z;
		logic       lt;
		logic       hold;
		logic [3:0] sh;
		sh = it.operand_b[3:0];
		v = 1'b0;
		sum = 0;
		case (it.alu_op)
			alu_add: sum = int'($signed(it.operand_a)) + int'($signed(it.operand_b));
			alu_sub: sum = int'($signed(it.operand_a)) - int'($signed(it.operand_b));
			default: sum = 0;
		endcase
		case (it.alu_op)
			alu_add, alu_sub: begin
				res = word_t'(sum);
				v = (sum > 32767) || (sum < -32768);
			end
			alu_and:    res = it.operand_a & it.operand_b;
			alu_or:     res = it.operand_a | it.operand_b;
			alu_xor:    res = it.operand_a ^ it.operand_b;
			alu_sll:    res = it.operand_a << sh;
			alu_srl:    res = it.operand_a >> sh;
			alu_sra:    res = (it.operand_a >> sh) | (it.operand_a[15] ? ~(16'hffff >> sh) : 16'h0);
			alu_pass_b: res = it.operand_b;
			default:    res = '0;
		endcase
		z = (res == 16'h0);
		lt = res[15] ^ v;
		case (it.bj_cond.cond)
			cond_eq:  hold = z;
			cond_ne:  hold = !z;
			cond_lt:  hold = lt;
			cond_ge:  hold = !lt;
			cond_gt:  hold = !z && !lt;
			cond_le:  hold = z || lt;
			cond_ovf: hold = v;
			default:  hold = 1'b1;
		endcase
		w.dest        = it.dest;
		w.we_rf       = it.we_rf;
		w.redirect    = (it.bj_cond.kind == ctrl_jump) || (it.bj_cond.kind == ctrl_branch && hold);
		w.redirect_pc = it.pc + it.offset;
		w.wb_data     = it.wb_sel ? model_mem[res[MEM_AW-1:0]] : res;
		if (it.we_mem) begin
			model_mem[res[MEM_AW-1:0]] = it.sdata;
		end
		return w;
	endfunction

	task automatic check_field(input string name, input logic [15:0] got, input logic [15:0] want);
		if (got !== want) begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, want, $time);
			error_count++;
		end
	endtask

	task automatic check_drained();
		if (exp_q.size() != 0) begin
			$display("%0d expected results never left the DUT", exp_q.size());
			error_count++;
		end
	endtask

	always @(posedge clk) begin : monitor
		wb_t want;
		int  t0;
		if (rst_n) begin
			cycle++;
			if (!seen_input && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
				$display("pipeline not idle after reset: out_valid %b in_ready %b", out_valid, in_ready);
				error_count++;
			end
			if (out_valid && !out_ready) begin
				last_stall = cycle;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("DUT delivered a result with nothing expected at %0t", $time);
					error_count++;
				end else begin
					want = exp_q.pop_front();
					t0 = accept_q.pop_front();
					check_field("dest", 16'(out_data.dest), 16'(want.dest));
					check_field("we_rf", 16'(out_data.we_rf), 16'(want.we_rf));
					check_field("wb_data", out_data.wb_data, want.wb_data);
					check_field("redirect", 16'(out_data.redirect), 16'(want.redirect));
					check_field("redirect_pc", out_data.redirect_pc, want.redirect_pc);
					// without back-pressure in between the result leaves two edges after acceptance
					if (last_stall <= t0 && cycle - t0 != 2) begin
						$display("result left %0d edges after acceptance instead of 2", cycle - t0);
						error_count++;
					end
				end
			end
			if (in_valid && in_ready) begin
				seen_input = 1'b1;
				exp_q.push_back(predict(in_data));
				accept_q.push_back(cycle);
			end
		end
	end

endmodule

// ==== tests/stage_reg_assertions.sv ====
`timescale 1ns/1ns

module stage_reg_assertions #(
	parameter int W = 1
) (
	input logic         clk,
	input logic         rst_n,
	input logic         in_ready,
	input logic         out_valid,
	input logic         out_ready,
	input logic [W-1:0] out_data
);

	int fail_count = 0;

	// a held item keeps its valid and its payload until the consumer takes it
	held_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else begin
			$error("stage register changed an item it was holding");
			fail_count++;
		end

	reset_empty: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else begin
			$error("stage register reports valid data during reset");
			fail_count++;
		end

	ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
		in_ready == (!out_valid || out_ready))
		else begin
			$error("stage register ready does not follow its fill state");
			fail_count++;
		end

endmodule

// ==== tests/tb_exec_backend.sv ====
`timescale 1ns/1ns

module tb_exec_backend;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int N_ALU   = 60;
	localparam int N_COND  = 6;
	localparam int N_MEM   = 80;
	localparam int N_LAT   = 10;
	localparam int N_MIX   = 120;
	localparam int N_ITEMS = N_ALU + 8 * N_COND + N_MEM + N_LAT + N_MIX;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	issue_t      in_data;
	logic        out_valid;
	logic        out_ready;
	wb_t         out_data;
	logic        bp_mode;
	logic [31:0] stim_lfsr;
	logic [31:0] ready_lfsr;
	int          assert_errors;

	exec_backend u_exec_backend (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	backend_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	bind stage_reg stage_reg_assertions #(
		.W ($bits(out_data))
	) u_stage_reg_assertions (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[14:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// small values and the signed extremes make zero and overflow results common
	function automatic word_t pick_operand();
		case (rand_bits(2))
			2'd0:    return rand_bits(16);
			2'd1:    return rand_bits(3);
			2'd2:    return 16'h7fff;
			default: return 16'h8000;
		endcase
	endfunction

	// kind 0 is an ALU op, 1 a compare and branch, 2 a load or store, 3 any of them
	function automatic issue_t make_item(input int kind, input cond_t cond);
		issue_t it;
		int     k;
		it = '0;
		k = (kind == 3) ? int'(rand_bits(2)) % 3 : kind;
		it.operand_a = pick_operand();
		it.operand_b = pick_operand();
		it.offset    = rand_bits(16);
		it.sdata     = rand_bits(16);
		it.pc        = rand_bits(16);
		it.dest      = reg_idx_t'(rand_bits(3));
		it.we_rf     = 1'(rand_bits(1));
		if (k == 0) begin
			it.alu_op       = alu_op_t'(rand_bits(4) % 9);
			it.bj_cond.kind = ctrl_kind_t'(rand_bits(2) % 3);
			it.bj_cond.cond = cond_t'(rand_bits(3));
		end else if (k == 1) begin
			it.alu_op       = alu_sub;
			it.bj_cond.kind = (rand_bits(2) == 0) ? ctrl_jump : ctrl_branch;
			it.bj_cond.cond = cond;
		end else begin
			it.alu_op    = alu_add;
			it.operand_b = rand_bits(4);
			it.we_mem    = 1'(rand_bits(1));
			it.re_mem    = !it.we_mem;
			it.wb_sel    = it.re_mem;
			it.we_rf     = it.re_mem;
		end
		return it;
	endfunction

	task automatic issue_one(input issue_t it);
		in_valid <= 1'b1;
		in_data  <= it;
		do begin
			@(posedge clk);
		end while (!in_ready);
		in_valid <= 1'b0;
	endtask

	always @(posedge clk) begin
		ready_lfsr = lfsr_next(ready_lfsr);
		out_ready <= bp_mode ? ready_lfsr[0] : 1'b1;
	end

	initial begin
		stim_lfsr  = 32'he98d;
		ready_lfsr = 32'he98d;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		out_ready  = 1'b0;
		bp_mode    = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// a few idle cycles so the checker sees the empty pipeline
		repeat (3) @(posedge clk);
		for (int i = 0; i < N_ALU; i++) begin
			issue_one(make_item(0, cond_eq));
		end
		bp_mode <= 1'b1;
		for (int c = 0; c < 8; c++) begin
			for (int j = 0; j < N_COND; j++) begin
				issue_one(make_item(1, cond_t'(c)));
			end
		end
		for (int i = 0; i < N_MEM; i++) begin
			issue_one(make_item(2, cond_eq));
		end
		bp_mode <= 1'b0;
		for (int i = 0; i < N_LAT; i++) begin
			issue_one(make_item(3, cond_eq));
			repeat (3) @(posedge clk);
		end
		bp_mode <= 1'b1;
		for (int i = 0; i < N_MIX; i++) begin
			issue_one(make_item(3, cond_eq));
			if (rand_bits(2) == 0) begin
				@(posedge clk);
			end
		end
		bp_mode <= 1'b0;
		for (int i = 0; i < 50 && u_checker.exp_q.size() != 0; i++) begin
			@(posedge clk);
		end
		u_checker.check_drained();
		assert_errors = u_exec_backend.u_ex_mem.u_stage_reg_assertions.fail_count
			+ u_exec_backend.u_mem_wb.u_stage_reg_assertions.fail_count;
		$display("run complete: %0d items, %0d checker errors, %0d assertion errors",
			N_ITEMS, u_checker.error_count, assert_errors);
		if (u_checker.error_count == 0 && assert_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		repeat (N_ITEMS * 40 + 200) @(posedge clk);
		$display("watchdog expired with %0d results still outstanding", u_checker.exp_q.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
